//--- build.f
+incdir+.
panel_pkg.sv
button_conditioner.sv
panel_mode_ctrl.sv
wb_bus_master.sv
seg_display_driver.sv
tpu_panel_top.sv
tb_tpu_panel.sv

//--- button_conditioner.sv
`timescale 1ns/10ps
`include "panel_config.svh"

module button_conditioner #(
    parameter int debounce_cycles = `PANEL_DEBOUNCE_CYCLES
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  panel_pkg::button_set_t btn,     // Raw, possibly bouncing
    output panel_pkg::button_set_t press    // One cycle per press
);

    // Counter just wide enough for the sample period
    localparam int CW = (debounce_cycles > 1) ? $clog2(debounce_cycles) : 1;

    logic [CW-1:0]             sample_cnt;
    logic                      sample_tick;
    logic [`PANEL_NUM_BTN-1:0] sampled;     // Last sampled button value

    assign sample_tick = (sample_cnt == CW'(debounce_cycles - 1));

    // ====================
    // Sampling and edge detect
    // ====================
    // Bounces shorter than the period never show up between two samples,
    // so a plain 0 to 1 compare on the samples is enough
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_cnt <= '0;
            sampled    <= '0;
            press      <= '0;
        end else begin
            press <= '0;                        // Pulse lasts one cycle
            if (sample_tick) begin
                sample_cnt <= '0;
                sampled    <= btn;
                press      <= btn & ~sampled;   // Newly pressed bits
            end else begin
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

endmodule

//--- panel_config.svh
`ifndef PANEL_CONFIG_SVH
`define PANEL_CONFIG_SVH

// ====================
// Bus geometry
// ====================
`define PANEL_BUS_DW        32          // Wishbone data width
`define PANEL_BUS_AW        12          // Region (2) plus offset (10)

// Region codes in wb_adr[11:10]
`define PANEL_REGION_UB     2'd0        // Unified buffer
`define PANEL_REGION_WT     2'd1        // Weight memory
`define PANEL_REGION_INSTR  2'd2        // Instruction memory

// ====================
// Panel timing defaults
// ====================
`define PANEL_DEBOUNCE_CYCLES 1048576   // About 10 ms at 100 MHz
`define PANEL_REFRESH_CYCLES  100000    // 1 ms per digit
`define PANEL_NUM_BTN       5
`define PANEL_NUM_DIGITS    4

`endif

//--- panel_mode_ctrl.sv
`timescale 1ns/10ps
`include "panel_config.svh"

module panel_mode_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  panel_pkg::button_set_t   press,
    input  logic [15:0]              sw,
    input  panel_pkg::core_status_t  status,
    input  logic                     bus_idle,
    input  logic [`PANEL_BUS_DW-1:0] rd_data,
    input  logic                     rd_valid,
    output panel_pkg::bus_req_t      req,
    output logic                     req_valid,
    output logic                     start_execution,
    output logic [15:0]              disp_value,
    output logic [15:0]              led
);

    localparam int OW = `PANEL_BUS_AW - 2;  // Offset width
    localparam int DW = `PANEL_BUS_DW;

    panel_pkg::panel_mode_e mode;
    panel_pkg::panel_mode_e mode_next;
    panel_pkg::bus_req_t    req_next;
    logic [4:0]             instr_ptr;      // Wraps at 32 entries
    logic [7:0]             rd_ptr;         // Results browse pointer
    logic [7:0]             rd_ptr_next;
    logic [15:0]            rd_word;        // Last word read back
    logic                   want_issue;
    logic                   issue;

    // ====================
    // Mode stepping
    // ====================
    always_comb begin
        mode_next = mode;
        if (press.up) begin                 // Up wins over Down
            case (mode)
                panel_pkg::MODE_IDLE:    mode_next = panel_pkg::MODE_INSTR;
                panel_pkg::MODE_INSTR:   mode_next = panel_pkg::MODE_DATA;
                panel_pkg::MODE_DATA:    mode_next = panel_pkg::MODE_WEIGHT;
                panel_pkg::MODE_WEIGHT:  mode_next = panel_pkg::MODE_EXECUTE;
                panel_pkg::MODE_EXECUTE: mode_next = panel_pkg::MODE_RESULTS;
                default:                 mode_next = panel_pkg::MODE_IDLE;
            endcase
        end else if (press.down) begin
            case (mode)
                panel_pkg::MODE_IDLE:    mode_next = panel_pkg::MODE_RESULTS;
                panel_pkg::MODE_INSTR:   mode_next = panel_pkg::MODE_IDLE;
                panel_pkg::MODE_DATA:    mode_next = panel_pkg::MODE_INSTR;
                panel_pkg::MODE_WEIGHT:  mode_next = panel_pkg::MODE_DATA;
                panel_pkg::MODE_EXECUTE: mode_next = panel_pkg::MODE_WEIGHT;
                default:                 mode_next = panel_pkg::MODE_EXECUTE;
            endcase
        end
    end

    // Left steps back, Right forward
    always_comb begin
        rd_ptr_next = rd_ptr;
        if (press.left)
            rd_ptr_next = rd_ptr - 8'd1;
        else if (press.right)
            rd_ptr_next = rd_ptr + 8'd1;
    end

    // ====================
    // Request decode
    // ====================
    always_comb begin
        want_issue = 1'b0;
        req_next   = '0;
        case (mode)
            panel_pkg::MODE_INSTR: if (press.center) begin
                want_issue      = 1'b1;
                req_next.op     = panel_pkg::OP_INSTR_WRITE;
                req_next.offset = OW'(instr_ptr);
                req_next.wdata  = DW'({sw, 2'b00});   // Word aligned
            end
            panel_pkg::MODE_DATA: if (press.center) begin
                want_issue      = 1'b1;
                req_next.op     = panel_pkg::OP_UB_WRITE;
                req_next.offset = OW'(sw[15:8]);
                req_next.wdata  = DW'(sw);
            end
            panel_pkg::MODE_WEIGHT: if (press.center) begin
                want_issue      = 1'b1;
                req_next.op     = panel_pkg::OP_WT_WRITE;
                req_next.offset = OW'(sw[15:6]);
                req_next.wdata  = DW'(sw);
            end
            panel_pkg::MODE_RESULTS: if (press.left || press.right || press.center) begin
                want_issue      = 1'b1;
                req_next.op     = panel_pkg::OP_UB_READ;
                req_next.offset = OW'(rd_ptr_next);   // Read at the moved pointer
            end
            default: ;
        endcase
    end

    // Pending req_valid counts as busy too
    assign issue = want_issue && bus_idle && !req_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode            <= panel_pkg::MODE_IDLE;
            instr_ptr       <= '0;
            rd_ptr          <= '0;
            req_valid       <= 1'b0;
            start_execution <= 1'b0;
            rd_word         <= '0;
        end else begin
            mode            <= mode_next;
            req_valid       <= issue;
            start_execution <= (mode == panel_pkg::MODE_EXECUTE) && press.center;
            if (issue && mode == panel_pkg::MODE_INSTR)
                instr_ptr <= instr_ptr + 5'd1;
            if (issue && mode == panel_pkg::MODE_RESULTS)
                rd_ptr <= rd_ptr_next;      // Dropped presses leave it alone
            if (rd_valid)
                rd_word <= rd_data[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (issue)
            req <= req_next;
    end

    // ====================
    // Display and LEDs
    // ====================
    always_comb begin
        case (mode)
            panel_pkg::MODE_IDLE:    disp_value = {10'd0, status};
            panel_pkg::MODE_INSTR:   disp_value = {3'd0, instr_ptr, 4'd0, sw[15:12]};
            panel_pkg::MODE_DATA:    disp_value = sw;
            panel_pkg::MODE_WEIGHT:  disp_value = {8'd0, sw[7:0]};
            panel_pkg::MODE_EXECUTE: disp_value = {12'd0, status.sys_busy, status.vpu_busy, 2'd0};
            default:                 disp_value = rd_word;
        endcase
    end

    assign led = {mode, 5'd0, rd_ptr};      // Mode on top, pointer low

endmodule

//--- panel_pkg.sv
`include "panel_config.svh"

package panel_pkg;

    // Panel modes in Up order, Down walks backwards
    typedef enum logic [2:0] {
        MODE_IDLE    = 3'd0,    // Core status
        MODE_INSTR   = 3'd1,    // Instruction entry
        MODE_DATA    = 3'd2,    // Unified buffer entry
        MODE_WEIGHT  = 3'd3,    // Weight entry
        MODE_EXECUTE = 3'd4,    // Start the core
        MODE_RESULTS = 3'd5     // Browse unified buffer
    } panel_mode_e;

    // Single-word bus operations
    typedef enum logic [1:0] {
        OP_UB_WRITE    = 2'd0,
        OP_WT_WRITE    = 2'd1,
        OP_INSTR_WRITE = 2'd2,
        OP_UB_READ     = 2'd3
    } bus_op_e;

    // Raw buttons and press pulses share this layout
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic center;
    } button_set_t;

    // One request from the mode controller to the bus master
    typedef struct packed {
        bus_op_e                   op;
        logic [`PANEL_BUS_AW-3:0]  offset;  // Region bits added by the master
        logic [`PANEL_BUS_DW-1:0]  wdata;   // Ignored on reads
    } bus_req_t;

    // Status flags from the tensor core
    typedef struct packed {
        logic sys_busy;
        logic sys_done;
        logic vpu_busy;
        logic vpu_done;
        logic ub_busy;
        logic ub_done;
    } core_status_t;

endpackage

//--- seg_display_driver.sv
`timescale 1ns/10ps
`include "panel_config.svh"

module seg_display_driver #(
    parameter int refresh_cycles = `PANEL_REFRESH_CYCLES
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [4*`PANEL_NUM_DIGITS-1:0] disp_value,
    output logic [6:0]                     seg,    // g..a, active low
    output logic [`PANEL_NUM_DIGITS-1:0]   an,     // Active low
    output logic                           dp
);

    localparam int RW = (refresh_cycles > 1) ? $clog2(refresh_cycles) : 1;
    localparam int SW = $clog2(`PANEL_NUM_DIGITS);

    logic [RW-1:0] refresh_cnt;
    logic [SW-1:0] digit;                   // 0 is the rightmost digit
    logic [3:0]    nibble;

    // Standard hex font
    function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0: hex_to_seg = 7'b1000000;
            4'h1: hex_to_seg = 7'b1111001;
            4'h2: hex_to_seg = 7'b0100100;
            4'h3: hex_to_seg = 7'b0110000;
            4'h4: hex_to_seg = 7'b0011001;
            4'h5: hex_to_seg = 7'b0010010;
            4'h6: hex_to_seg = 7'b0000010;
            4'h7: hex_to_seg = 7'b1111000;
            4'h8: hex_to_seg = 7'b0000000;
            4'h9: hex_to_seg = 7'b0010000;
            4'hA: hex_to_seg = 7'b0001000;
            4'hB: hex_to_seg = 7'b0000011;
            4'hC: hex_to_seg = 7'b1000110;
            4'hD: hex_to_seg = 7'b0100001;
            4'hE: hex_to_seg = 7'b0000110;
            default: hex_to_seg = 7'b0001110;  // F
        endcase
    endfunction

    // ====================
    // Digit rotation
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refresh_cnt <= '0;
            digit       <= '0;
        end else if (refresh_cnt == RW'(refresh_cycles - 1)) begin
            refresh_cnt <= '0;
            digit       <= digit + 1'b1;    // Wraps after the last digit
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    // One anode low at a time
    always_comb begin
        an        = '1;
        an[digit] = 1'b0;
    end

    assign nibble = disp_value[digit*4 +: 4];
    assign seg    = hex_to_seg(nibble);
    assign dp     = 1'b1;                   // Decimal point unused

endmodule

//--- tb_panel_model.svh
`ifndef TB_PANEL_MODEL_SVH
`define TB_PANEL_MODEL_SVH

// One expected Wishbone transfer
typedef struct packed {
    logic                     we;
    logic [`PANEL_BUS_AW-1:0] adr;
    logic [`PANEL_BUS_DW-1:0] dat;
} xfer_t;

panel_pkg::panel_mode_e   m_mode      = panel_pkg::MODE_IDLE;
logic [4:0]               m_instr_ptr = '0;
logic [7:0]               m_rd_ptr    = '0;
logic [15:0]              m_last_word = '0;    // Low half of the last read
int                       m_starts    = 0;     // Start pulses so far
xfer_t                    exp_q[$];            // Transfers still to start
logic [`PANEL_BUS_DW-1:0] m_mem[logic [`PANEL_BUS_AW-1:0]];

// Six modes on a ring
function automatic panel_pkg::panel_mode_e step_mode(input panel_pkg::panel_mode_e m,
                                                     input bit forward);
    int idx;
    idx = forward ? (int'(m) + 1) % 6 : (int'(m) + 5) % 6;
    return panel_pkg::panel_mode_e'(idx[2:0]);
endfunction

// Lit segments in gfedcba order, the panel drives them inverted
function automatic logic [6:0] seg_pattern(input logic [3:0] hex);
    logic [6:0] lit;
    case (hex)
        4'h0: lit = 7'h3F;
        4'h1: lit = 7'h06;
        4'h2: lit = 7'h5B;
        4'h3: lit = 7'h4F;
        4'h4: lit = 7'h66;
        4'h5: lit = 7'h6D;
        4'h6: lit = 7'h7D;
        4'h7: lit = 7'h07;
        4'h8: lit = 7'h7F;
        4'h9: lit = 7'h6F;
        4'hA: lit = 7'h77;
        4'hB: lit = 7'h7C;
        4'hC: lit = 7'h39;
        4'hD: lit = 7'h5E;
        4'hE: lit = 7'h79;
        default: lit = 7'h71;
    endcase
    return ~lit;
endfunction

function automatic logic [15:0] expected_display();
    case (m_mode)
        panel_pkg::MODE_IDLE:    return 16'(status);
        panel_pkg::MODE_INSTR:   return (16'(m_instr_ptr) << 8) | 16'(sw[15:12]);
        panel_pkg::MODE_DATA:    return sw;
        panel_pkg::MODE_WEIGHT:  return sw & 16'h00ff;
        panel_pkg::MODE_EXECUTE: return 16'({status.sys_busy, status.vpu_busy}) << 2;
        default:                 return m_last_word;
    endcase
endfunction

// Advance the model by one press, queue the transfer it should cause
task automatic apply_press(input panel_pkg::button_set_t b, input bit accepted);
    xfer_t      x;
    logic [7:0] ptr;
    x   = '0;
    ptr = m_rd_ptr;
    if (b.up || b.down) begin
        m_mode = step_mode(m_mode, b.up);       // Up first
        return;
    end
    if (m_mode == panel_pkg::MODE_EXECUTE && b.center)
        m_starts++;
    if (!accepted)
        return;                                 // Bus busy, press lost
    if (m_mode == panel_pkg::MODE_RESULTS) begin
        if (b.left)
            ptr = ptr - 8'd1;
        else if (b.right)
            ptr = ptr + 8'd1;
        else if (!b.center)
            return;
        m_rd_ptr    = ptr;
        x.adr       = {`PANEL_REGION_UB, 2'b00, ptr};
        x.dat       = m_mem.exists(x.adr) ? m_mem[x.adr] : '0;
        m_last_word = x.dat[15:0];
        exp_q.push_back(x);
        return;
    end
    if (!b.center)
        return;
    x.we = 1'b1;
    case (m_mode)
        panel_pkg::MODE_INSTR: begin
            x.adr       = {`PANEL_REGION_INSTR, 5'd0, m_instr_ptr};
            x.dat       = 32'(sw) << 2;
            m_instr_ptr = m_instr_ptr + 5'd1;   // 32 entries
        end
        panel_pkg::MODE_DATA: begin
            x.adr = {`PANEL_REGION_UB, 2'b00, sw[15:8]};
            x.dat = 32'(sw);
        end
        panel_pkg::MODE_WEIGHT: begin
            x.adr = {`PANEL_REGION_WT, sw[15:6]};
            x.dat = 32'(sw);
        end
        default: return;
    endcase
    m_mem[x.adr] = x.dat;
    exp_q.push_back(x);
endtask

`endif

//--- tb_tpu_panel.sv
`timescale 1ns/10ps
`include "panel_config.svh"

module tb_tpu_panel;

    // About 125 presses of 25 cycles plus one 40-cycle stall with wide margin
    localparam int MAX_CYCLES = 20000;
    localparam int REFRESH_CYCLES = 8;         // Cycles per display digit
    localparam panel_pkg::button_set_t BTN_UP     = 5'b10000;
    localparam panel_pkg::button_set_t BTN_DOWN   = 5'b01000;
    localparam panel_pkg::button_set_t BTN_LEFT   = 5'b00100;
    localparam panel_pkg::button_set_t BTN_RIGHT  = 5'b00010;
    localparam panel_pkg::button_set_t BTN_CENTER = 5'b00001;

    logic                     clk;
    logic                     rst_n;
    logic [15:0]              sw;
    panel_pkg::button_set_t   btn;
    panel_pkg::core_status_t  status;
    logic [6:0]               seg;
    logic [3:0]               an;
    logic                     dp;
    logic [15:0]              led;
    logic                     start_execution;
    logic                     wb_cyc, wb_stb, wb_we, wb_ack;
    logic [`PANEL_BUS_AW-1:0] wb_adr;
    logic [`PANEL_BUS_DW-1:0] wb_dat_o, wb_dat_i;

    `include "tb_panel_model.svh"

    int   error_count   = 0;
    int   cycle_count   = 0;
    int   scan_cycles   = 0;           // Clock edges since reset release
    int   start_seen    = 0;
    int   digit_idx;
    int   wait_left     = 0;
    bit   disp_check_en = 1'b0;        // Only while the panel has settled
    bit   stall_next    = 1'b0;        // Hold the next ack back
    bit   start_prev    = 1'b0;
    bit   in_xfer       = 1'b0;
    xfer_t held;                       // Transfer as first seen
    logic [6:0]               exp_seg;
    logic [3:0]               exp_an;
    logic [`PANEL_BUS_DW-1:0] slave_mem[logic [`PANEL_BUS_AW-1:0]];

    tpu_panel_top #(.debounce_cycles(4), .refresh_cycles(REFRESH_CYCLES)) DUT (
        .clk(clk), .rst_n(rst_n), .sw(sw), .btn(btn), .status(status),
        .seg(seg), .an(an), .dp(dp), .led(led), .start_execution(start_execution),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        error_count++;
        $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    // Index of the single low anode or -1
    function automatic int active_digit(input logic [3:0] sel);
        int found;
        found = -1;
        for (int i = 0; i < 4; i++)
            if (!sel[i])
                found = (found == -1) ? i : -2;
        return (found < 0) ? -1 : found;
    endfunction

    task automatic check_transfer(input xfer_t got);
        xfer_t exp;
        assert (exp_q.size() > 0) else report_problem("bus transfer started with none expected");
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            assert (got.we == exp.we) else report_mismatch("wb_we", exp.we, got.we);
            assert (got.adr == exp.adr) else report_mismatch("wb_adr", exp.adr, got.adr);
            if (exp.we)
                assert (got.dat == exp.dat) else report_mismatch("wb_dat_o", exp.dat, got.dat);
        end
    endtask

    // Held 12 cycles and released 12 with the display checked late in the release
    task automatic press_button(input panel_pkg::button_set_t b, input logic [15:0] sw_val,
                                input bit accepted);
        @(negedge clk);
        sw     = sw_val;
        status = 6'($urandom);
        btn    = b;
        apply_press(b, accepted);
        repeat (12) @(negedge clk);
        btn = '0;
        repeat (4) @(negedge clk);
        disp_check_en = 1'b1;
        repeat (8) @(negedge clk);
        disp_check_en = 1'b0;
        assert (exp_q.size() == 0) else report_problem("an expected bus transfer never started");
        assert (start_seen == m_starts) else report_mismatch("start count", m_starts, start_seen);
        assert (led[15:13] == m_mode) else report_mismatch("led[15:13]", m_mode, led[15:13]);
        assert (led[12:0] == {5'd0, m_rd_ptr})
            else report_mismatch("led[12:0]", m_rd_ptr, led[12:0]);
    endtask

    task automatic go_to_mode(input panel_pkg::panel_mode_e target);
        while (m_mode != target)
            press_button(BTN_UP, 16'($urandom), 1'b1);
    endtask

    // ====================
    // Wishbone slave
    // ====================
    always @(negedge clk) begin
        assert (wb_stb == wb_cyc) else report_mismatch("wb_stb", wb_cyc, wb_stb);
        if (wb_ack) begin
            wb_ack  = 1'b0;
            in_xfer = 1'b0;
            assert (!wb_cyc) else report_problem("wb_cyc still high the cycle after ack");
        end else if (wb_cyc && wb_stb) begin
            if (!in_xfer) begin                 // First cycle of a transfer
                in_xfer    = 1'b1;
                held.we    = wb_we;
                held.adr   = wb_adr;
                held.dat   = wb_dat_o;
                wait_left  = stall_next ? 40 : $urandom_range(5, 0);
                stall_next = 1'b0;
                check_transfer(held);
            end else begin                      // Must hold still under back-pressure
                assert (wb_adr == held.adr) else report_mismatch("wb_adr", held.adr, wb_adr);
                assert (wb_dat_o == held.dat) else report_mismatch("wb_dat_o", held.dat, wb_dat_o);
                assert (wb_we == held.we) else report_mismatch("wb_we", held.we, wb_we);
            end
            if (wait_left == 0) begin
                wb_ack = 1'b1;
                if (wb_we)
                    slave_mem[wb_adr] = wb_dat_o;
                else
                    wb_dat_i = slave_mem.exists(wb_adr) ? slave_mem[wb_adr] : '0;
            end else begin
                wait_left--;
            end
        end
    end

    // ====================
    // Display and start monitors
    // ====================
    always @(negedge clk) begin
        if (rst_n) begin
            digit_idx = active_digit(an);
            assert (digit_idx >= 0) else report_problem("an does not have exactly one digit low");
            exp_an = ~(4'b0001 << ((scan_cycles / REFRESH_CYCLES) % 4));   // Digit 0 first
            assert (an == exp_an) else report_mismatch("an", exp_an, an);
            assert (dp === 1'b1) else report_mismatch("dp", 1'b1, dp);
            if (disp_check_en && digit_idx >= 0) begin
                exp_seg = seg_pattern(4'(expected_display() >> (4 * digit_idx)));
                assert (seg == exp_seg) else report_mismatch("seg", exp_seg, seg);
            end
            if (start_execution) begin
                start_seen++;
                assert (!start_prev) else report_problem("start_execution high for two cycles");
            end
        end
        start_prev = start_execution;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (rst_n)
            scan_cycles++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors: %0d", error_count + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ====================
    // Stimulus
    // ====================
    initial begin
        int seed;
        int pick;
        seed     = $urandom(33);
        rst_n    = 1'b0;
        sw       = '0;
        btn      = '0;
        status   = '0;
        wb_ack   = 1'b0;
        wb_dat_i = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (led[15:13] == 3'd0) else report_mismatch("led[15:13]", 3'd0, led[15:13]);
        assert (!start_execution) else report_mismatch("start_execution", 0, start_execution);
        assert (!wb_cyc) else report_mismatch("wb_cyc", 0, wb_cyc);
        assert (an == 4'b1110) else report_mismatch("an", 4'b1110, an);

        repeat (30)                             // Random walk around the ring
            press_button($urandom_range(1, 0) ? BTN_UP : BTN_DOWN, 16'($urandom), 1'b1);

        go_to_mode(panel_pkg::MODE_INSTR);
        repeat (34)                             // Pointer wraps past 31
            press_button(BTN_CENTER, 16'($urandom), 1'b1);
        stall_next = 1'b1;                      // Slow ack and a press into it
        press_button(BTN_CENTER, 16'($urandom), 1'b1);
        assert (wb_cyc) else report_problem("stalled transfer ended too early");
        press_button(BTN_CENTER, 16'($urandom), 1'b0);
        while (wb_cyc)
            @(negedge clk);
        press_button(BTN_CENTER, 16'($urandom), 1'b1);

        go_to_mode(panel_pkg::MODE_DATA);
        for (int i = -2; i <= 2; i++)           // Words around offset 0 for reads
            press_button(BTN_CENTER, {8'(i), 8'($urandom)}, 1'b1);
        go_to_mode(panel_pkg::MODE_WEIGHT);
        repeat (4)
            press_button(BTN_CENTER, 16'($urandom), 1'b1);

        go_to_mode(panel_pkg::MODE_RESULTS);
        repeat (24) begin
            pick = $urandom_range(2, 0);
            press_button(pick == 0 ? BTN_LEFT : (pick == 1 ? BTN_RIGHT : BTN_CENTER),
                         16'($urandom), 1'b1);
        end

        press_button(BTN_DOWN, 16'($urandom), 1'b1);    // Results back to execute
        repeat (2)
            press_button(BTN_CENTER, 16'($urandom), 1'b1);

        $display("Errors: %0d", error_count);
        if (error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- tpu_panel_top.sv
`timescale 1ns/10ps
`include "panel_config.svh"

module tpu_panel_top #(
    parameter int debounce_cycles = `PANEL_DEBOUNCE_CYCLES,
    parameter int refresh_cycles  = `PANEL_REFRESH_CYCLES
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [15:0]              sw,
    input  panel_pkg::button_set_t   btn,
    input  panel_pkg::core_status_t  status,
    // 7-segment display
    output logic [6:0]               seg,
    output logic [3:0]               an,
    output logic                     dp,
    output logic [15:0]              led,
    output logic                     start_execution,
    // Wishbone master to the core memories
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [`PANEL_BUS_AW-1:0] wb_adr,
    output logic [`PANEL_BUS_DW-1:0] wb_dat_o,
    input  logic [`PANEL_BUS_DW-1:0] wb_dat_i,
    input  logic                     wb_ack
);

    panel_pkg::button_set_t   press;
    panel_pkg::bus_req_t      req;
    logic                     req_valid;
    logic                     bus_idle;
    logic [`PANEL_BUS_DW-1:0] rd_data;
    logic                     rd_valid;
    logic [15:0]              disp_value;

    button_conditioner #(.debounce_cycles(debounce_cycles)) u_btn (
        .clk(clk), .rst_n(rst_n), .btn(btn), .press(press)
    );

    panel_mode_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .press(press), .sw(sw), .status(status),
        .bus_idle(bus_idle), .rd_data(rd_data), .rd_valid(rd_valid),
        .req(req), .req_valid(req_valid), .start_execution(start_execution),
        .disp_value(disp_value), .led(led)
    );

    wb_bus_master u_wb (
        .clk(clk), .rst_n(rst_n), .req(req), .req_valid(req_valid),
        .bus_idle(bus_idle), .rd_data(rd_data), .rd_valid(rd_valid),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    seg_display_driver #(.refresh_cycles(refresh_cycles)) u_disp (
        .clk(clk), .rst_n(rst_n), .disp_value(disp_value),
        .seg(seg), .an(an), .dp(dp)
    );

endmodule

//--- wb_bus_master.sv
`timescale 1ns/10ps
`include "panel_config.svh"

module wb_bus_master (
    input  logic                     clk,
    input  logic                     rst_n,
    input  panel_pkg::bus_req_t      req,
    input  logic                     req_valid,
    output logic                     bus_idle,
    output logic [`PANEL_BUS_DW-1:0] rd_data,
    output logic                     rd_valid,
    // Wishbone classic master
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [`PANEL_BUS_AW-1:0] wb_adr,
    output logic [`PANEL_BUS_DW-1:0] wb_dat_o,
    input  logic [`PANEL_BUS_DW-1:0] wb_dat_i,
    input  logic                     wb_ack
);

    typedef enum logic {
        ST_IDLE,
        ST_ACTIVE                           // cyc and stb up, waiting for ack
    } wb_state_e;

    wb_state_e state;
    logic      start;
    logic      done;

    // Memory region for each opcode
    function automatic logic [1:0] op_region(input panel_pkg::bus_op_e op);
        case (op)
            panel_pkg::OP_WT_WRITE:    op_region = `PANEL_REGION_WT;
            panel_pkg::OP_INSTR_WRITE: op_region = `PANEL_REGION_INSTR;
            default:                   op_region = `PANEL_REGION_UB;
        endcase
    endfunction

    assign start = (state == ST_IDLE) && req_valid;
    assign done  = (state == ST_ACTIVE) && wb_ack;

    // ====================
    // Transfer FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            wb_we    <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= 1'b0;
            if (start) begin
                state <= ST_ACTIVE;
                wb_we <= (req.op != panel_pkg::OP_UB_READ);
            end else if (done) begin
                state    <= ST_IDLE;        // Drops cyc and stb next cycle
                wb_we    <= 1'b0;
                rd_valid <= !wb_we;
            end
        end
    end

    // Address and data held for the whole transfer
    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr   <= {op_region(req.op), req.offset};
            wb_dat_o <= req.wdata;
        end
        if (done && !wb_we)
            rd_data <= wb_dat_i;            // Read word captured at ack
    end

    assign wb_cyc   = (state == ST_ACTIVE);
    assign wb_stb   = (state == ST_ACTIVE); // Single transfer, no gaps
    assign bus_idle = (state == ST_IDLE);

endmodule
